/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ps2_mouse
RTL_TOP   ?= ps2_mouse_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

RTL_FILES = ps2_pkg.sv ps2_tx.sv ps2_rx.sv ps2_mouse_ctrl.sv ps2_mouse_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
ps2_pkg.sv
ps2_tx.sv
ps2_rx.sv
ps2_mouse_ctrl.sv
ps2_mouse_top.sv
ps2_mouse_model.sv
tb_ps2_mouse.sv

/* ps2_mouse_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_mouse_ctrl #(
	parameter int ACK_TIMEOUT_CYCLES = 1250000
) (
	input  wire logic                qzt_clk,
	input  wire logic                rst,
	input  wire logic                start,
	input  wire logic                tx_done,
	input  wire logic                tx_nack,
	input  wire logic                tx_busy,
	input  wire ps2_pkg::ps2_frame_t rx_frame,
	input  wire logic                rx_valid,
	output logic [7:0]               tx_byte,
	output logic                     tx_start,
	output logic                     rx_hold,
	output logic                     init_done,
	output logic                     init_err,
	output logic                     frame_err,
	output ps2_pkg::mouse_packet_t   packet,
	output logic                     packet_valid
);

	import ps2_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SEND,
		ST_WAIT_TX,
		ST_WAIT_ACK,
		ST_RUN
	} ctrl_state_t;

	localparam int ACK_W = $clog2(ACK_TIMEOUT_CYCLES + 1);
	localparam logic [ACK_W-1:0] ACK_LAST = ACK_W'(ACK_TIMEOUT_CYCLES - 1);

	ctrl_state_t      state;
	logic [1:0]       cmd_idx;
	logic [ACK_W-1:0] ack_tmr;
	logic             skip_id;
	logic [1:0]       slot;
	logic             frame_bad;
	ps2_status_u      first_byte;

	assign frame_bad      = rx_frame.parity_err | rx_frame.framing_err;
	assign first_byte.raw = rx_frame.data;

	// command order F2, EA, F4
	always_comb begin
		case (cmd_idx)
			2'd0:    tx_byte = CMD_GET_ID;
			2'd1:    tx_byte = CMD_STREAM;
			default: tx_byte = CMD_ENABLE;
		endcase
	end

	// keep our own outgoing frame out of the receiver
	assign rx_hold = tx_busy | (state == ST_WAIT_TX);

	//////////////////////////////////////////////////////////////////////
	// init and packet sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			state        <= ST_IDLE;
			cmd_idx      <= '0;
			ack_tmr      <= '0;
			skip_id      <= 1'b0;
			slot         <= '0;
			tx_start     <= 1'b0;
			init_done    <= 1'b0;
			init_err     <= 1'b0;
			frame_err    <= 1'b0;
			packet_valid <= 1'b0;
		end else begin
			tx_start     <= 1'b0;
			init_err     <= 1'b0;
			frame_err    <= 1'b0;
			packet_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						cmd_idx <= '0;
						skip_id <= 1'b0;
						state   <= ST_SEND;
					end
				end
				ST_SEND: begin
					tx_start <= 1'b1;
					state    <= ST_WAIT_TX;
				end
				ST_WAIT_TX: begin
					if (tx_nack) begin
						init_err <= 1'b1;
						state    <= ST_IDLE;
					end else if (tx_done) begin
						ack_tmr <= '0;
						state   <= ST_WAIT_ACK;
					end
				end
				ST_WAIT_ACK: begin
					ack_tmr <= ack_tmr + 1'b1;
					if (rx_valid) begin
						ack_tmr <= '0;
						if (frame_bad || (!skip_id && rx_frame.data != REPLY_ACK)) begin
							init_err <= 1'b1;
							state    <= ST_IDLE;
						end else if (skip_id) begin
							// id byte after F2, ignored
							skip_id <= 1'b0;
							cmd_idx <= cmd_idx + 1'b1;
							state   <= ST_SEND;
						end else if (cmd_idx == 2'd0) begin
							skip_id <= 1'b1;
						end else if (cmd_idx == 2'd2) begin
							init_done <= 1'b1;
							slot      <= '0;
							state     <= ST_RUN;
						end else begin
							cmd_idx <= cmd_idx + 1'b1;
							state   <= ST_SEND;
						end
					end else if (ack_tmr == ACK_LAST) begin
						init_err <= 1'b1;
						state    <= ST_IDLE;
					end
				end
				ST_RUN: begin
					if (rx_valid) begin
						if (frame_bad) begin
							frame_err <= 1'b1;
							slot      <= '0;
						end else begin
							case (slot)
								2'd0: begin
									// realign on the always-one bit
									if (first_byte.flags.always_one) begin
										packet.status <= first_byte;
										slot          <= 2'd1;
									end
								end
								2'd1: begin
									packet.dx <= rx_frame.data;
									slot      <= 2'd2;
								end
								default: begin
									packet.dy    <= rx_frame.data;
									packet_valid <= 1'b1;
									slot         <= '0;
								end
							endcase
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// packets only after the mouse has been set up
	assert property (@(posedge qzt_clk) disable iff (rst)
		packet_valid |-> init_done)
		else $error("ps2_mouse_ctrl: packet_valid before init_done");

endmodule

`default_nettype wire

/* ps2_mouse_model.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_mouse_model #(
	parameter int HALF_CYCLES = 10
) (
	input  wire logic qzt_clk,
	input  wire logic ps2_clk,
	input  wire logic ps2_dat,
	output logic      clk_low,
	output logic      dat_low
);

	// set by the testbench to keep the FA reply byte back
	logic       ack_mute;
	int         cmd_cnt;
	logic [7:0] cmd_log [0:7];
	logic       par_ok  [0:7];

	task automatic wait_half();
		repeat (HALF_CYCLES) @(negedge qzt_clk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// device to host, start bit first
	//////////////////////////////////////////////////////////////////////

	task automatic send_byte(input logic [7:0] b, input logic bad_par);
		logic [10:0] bits;
		bits = {1'b1, (~^b) ^ bad_par, b, 1'b0};
		for (int k = 0; k < 11; k++) begin
			dat_low = ~bits[k];
			wait_half();
			clk_low = 1'b1;
			wait_half();
			clk_low = 1'b0;
		end
		dat_low = 1'b0;
		wait_half();
	endtask

	// host to device, sampled at the end of each high phase
	task automatic recv_cmd(output logic [7:0] b, output logic ok);
		logic [9:0] bits;
		wait_half();
		for (int k = 0; k < 10; k++) begin
			clk_low = 1'b1;
			wait_half();
			clk_low = 1'b0;
			wait_half();
			bits[k] = ps2_dat;
		end
		// line acknowledge, data low before the eleventh fall
		dat_low = 1'b1;
		repeat (2) @(negedge qzt_clk);
		clk_low = 1'b1;
		wait_half();
		clk_low = 1'b0;
		dat_low = 1'b0;
		wait_half();
		b  = bits[7:0];
		ok = (^bits[8:0]) & bits[9];
	endtask

	initial begin
		logic [7:0] b;
		logic       ok;
		clk_low  = 1'b0;
		dat_low  = 1'b0;
		ack_mute = 1'b0;
		cmd_cnt  = 0;
		forever begin
			@(negedge qzt_clk);
			// request to send: data low from the host, clock released
			if (!ps2_dat && !dat_low && ps2_clk) begin
				recv_cmd(b, ok);
				if (cmd_cnt < 8) begin
					cmd_log[cmd_cnt] = b;
					par_ok[cmd_cnt]  = ok;
				end
				cmd_cnt++;
				if (!ack_mute) begin
					wait_half();
					send_byte(8'hFA, 1'b0);
					// device id for a plain mouse
					if (b == 8'hF2)
						send_byte(8'h00, 1'b0);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* ps2_mouse_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_mouse_top #(
	parameter int INHIBIT_CYCLES       = 5000,
	parameter int FRAME_TIMEOUT_CYCLES = 10000,
	parameter int ACK_TIMEOUT_CYCLES   = 1250000
) (
	input  wire logic              qzt_clk,
	input  wire logic              rst,
	input  wire logic              ps2_clk,
	input  wire logic              ps2_dat,
	output logic                   ps2_clk_low,
	output logic                   ps2_dat_low,
	input  wire logic              start,
	output logic                   init_done,
	output logic                   init_err,
	output logic                   frame_err,
	output ps2_pkg::mouse_packet_t packet,
	output logic                   packet_valid
);

	import ps2_pkg::*;

	logic [7:0] tx_byte;
	logic       tx_start;
	logic       tx_busy;
	logic       tx_done;
	logic       tx_nack;
	logic       rx_hold;
	logic       rx_valid;
	ps2_frame_t rx_frame;

	//////////////////////////////////////////////////////////////////////
	// line side, transmit and receive in parallel
	//////////////////////////////////////////////////////////////////////

	ps2_tx #(
		.INHIBIT_CYCLES       (INHIBIT_CYCLES),
		.FRAME_TIMEOUT_CYCLES (FRAME_TIMEOUT_CYCLES)
	) tx0 (
		.qzt_clk     (qzt_clk),
		.rst         (rst),
		.ps2_clk     (ps2_clk),
		.ps2_dat     (ps2_dat),
		.tx_byte     (tx_byte),
		.tx_start    (tx_start),
		.ps2_clk_low (ps2_clk_low),
		.ps2_dat_low (ps2_dat_low),
		.tx_busy     (tx_busy),
		.tx_done     (tx_done),
		.tx_nack     (tx_nack)
	);

	ps2_rx #(
		.FRAME_TIMEOUT_CYCLES (FRAME_TIMEOUT_CYCLES)
	) rx0 (
		.qzt_clk  (qzt_clk),
		.rst      (rst),
		.ps2_clk  (ps2_clk),
		.ps2_dat  (ps2_dat),
		.rx_hold  (rx_hold),
		.rx_frame (rx_frame),
		.rx_valid (rx_valid)
	);

	// command phase and packet assembly
	ps2_mouse_ctrl #(
		.ACK_TIMEOUT_CYCLES (ACK_TIMEOUT_CYCLES)
	) ctrl0 (
		.qzt_clk      (qzt_clk),
		.rst          (rst),
		.start        (start),
		.tx_done      (tx_done),
		.tx_nack      (tx_nack),
		.tx_busy      (tx_busy),
		.rx_frame     (rx_frame),
		.rx_valid     (rx_valid),
		.tx_byte      (tx_byte),
		.tx_start     (tx_start),
		.rx_hold      (rx_hold),
		.init_done    (init_done),
		.init_err     (init_err),
		.frame_err    (frame_err),
		.packet       (packet),
		.packet_valid (packet_valid)
	);

endmodule

`default_nettype wire

/* ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

	//////////////////////////////////////////////////////////////////////
	// frame and packet types
	//////////////////////////////////////////////////////////////////////

	// one received byte with its line checks
	typedef struct packed {
		logic [7:0] data;
		logic       parity_err;
		// bad start or stop bit
		logic       framing_err;
	} ps2_frame_t;

	// first packet byte, msb first
	typedef struct packed {
		logic y_ovf;
		logic x_ovf;
		logic y_sign;
		logic x_sign;
		// always set by the mouse, used to realign packets
		logic always_one;
		logic middle;
		logic right;
		logic left;
	} ps2_status_t;

	typedef union packed {
		logic [7:0]  raw;
		ps2_status_t flags;
	} ps2_status_u;

	typedef struct packed {
		ps2_status_u status;
		logic [7:0]  dx;
		logic [7:0]  dy;
	} mouse_packet_t;

	//////////////////////////////////////////////////////////////////////
	// command and reply bytes
	//////////////////////////////////////////////////////////////////////

	localparam logic [7:0] CMD_GET_ID = 8'hF2;
	localparam logic [7:0] CMD_STREAM = 8'hEA;
	localparam logic [7:0] CMD_ENABLE = 8'hF4;
	localparam logic [7:0] REPLY_ACK  = 8'hFA;

endpackage

`default_nettype wire

/* ps2_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_rx #(
	parameter int FRAME_TIMEOUT_CYCLES = 10000
) (
	input  wire logic         qzt_clk,
	input  wire logic         rst,
	input  wire logic         ps2_clk,
	input  wire logic         ps2_dat,
	input  wire logic         rx_hold,
	output ps2_pkg::ps2_frame_t rx_frame,
	output logic              rx_valid
);

	localparam int TMO_W = $clog2(FRAME_TIMEOUT_CYCLES + 1);
	localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(FRAME_TIMEOUT_CYCLES - 1);

	logic [1:0]       clk_sync;
	logic [1:0]       dat_sync;
	logic             clk_prev;
	logic             fall_q;
	logic             full;
	logic [3:0]       bit_cnt;
	// first bit in ends up at bit 0
	logic [10:0]      sh;
	logic [TMO_W-1:0] idle_tmr;

	//////////////////////////////////////////////////////////////////////
	// synchronizers and falling edge
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
			clk_prev <= 1'b1;
			fall_q   <= 1'b0;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			dat_sync <= {dat_sync[0], ps2_dat};
			clk_prev <= clk_sync[1];
			fall_q   <= clk_prev & ~clk_sync[1];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bit collection
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (rst || rx_hold) begin
			bit_cnt  <= '0;
			idle_tmr <= '0;
			full     <= 1'b0;
		end else begin
			full <= 1'b0;
			if (fall_q) begin
				sh       <= {dat_sync[1], sh[10:1]};
				idle_tmr <= '0;
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					full    <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (bit_cnt != 4'd0) begin
				// stalled frame, drop it quietly
				if (idle_tmr == TMO_LAST) begin
					bit_cnt  <= '0;
					idle_tmr <= '0;
				end else begin
					idle_tmr <= idle_tmr + 1'b1;
				end
			end
		end
	end

	// frame checks at the stop bit
	always_ff @(posedge qzt_clk) begin
		if (full) begin
			rx_frame.data        <= sh[8:1];
			rx_frame.parity_err  <= ~^sh[9:1];
			rx_frame.framing_err <= sh[0] | ~sh[10];
		end
	end

	always_ff @(posedge qzt_clk) begin
		if (rst)
			rx_valid <= 1'b0;
		else
			rx_valid <= full;
	end

	// a frame is eleven clock falls long
	assert property (@(posedge qzt_clk) disable iff (rst)
		rx_valid |=> !rx_valid)
		else $error("ps2_rx: rx_valid high on consecutive cycles");

endmodule

`default_nettype wire

/* ps2_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_tx #(
	parameter int INHIBIT_CYCLES       = 5000,
	parameter int FRAME_TIMEOUT_CYCLES = 10000
) (
	input  wire logic       qzt_clk,
	input  wire logic       rst,
	input  wire logic       ps2_clk,
	input  wire logic       ps2_dat,
	input  wire logic [7:0] tx_byte,
	input  wire logic       tx_start,
	output logic            ps2_clk_low,
	output logic            ps2_dat_low,
	output logic            tx_busy,
	output logic            tx_done,
	output logic            tx_nack
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_INHIBIT,
		ST_REQUEST,
		ST_SHIFT,
		ST_ACK
	} tx_state_t;

	// one timer serves the inhibit window and the clock gap limit
	localparam int TMR_MAX = (INHIBIT_CYCLES > FRAME_TIMEOUT_CYCLES) ?
		INHIBIT_CYCLES : FRAME_TIMEOUT_CYCLES;
	localparam int TMR_W = $clog2(TMR_MAX + 1);

	localparam logic [TMR_W-1:0] INH_HALF = TMR_W'(INHIBIT_CYCLES / 2);
	localparam logic [TMR_W-1:0] INH_LAST = TMR_W'(INHIBIT_CYCLES - 1);
	localparam logic [TMR_W-1:0] GAP_LAST = TMR_W'(FRAME_TIMEOUT_CYCLES - 1);

	tx_state_t        state;
	logic [TMR_W-1:0] tmr;
	logic [3:0]       bit_cnt;
	// stop, parity, data lsb first, start
	logic [10:0]      sh;
	logic [1:0]       clk_sync;
	logic [1:0]       dat_sync;
	logic             clk_prev;
	logic             fall;

	//////////////////////////////////////////////////////////////////////
	// line synchronizers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			dat_sync <= {dat_sync[0], ps2_dat};
			clk_prev <= clk_sync[1];
		end
	end

	assign fall = clk_prev & ~clk_sync[1];

	//////////////////////////////////////////////////////////////////////
	// transmit FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			state       <= ST_IDLE;
			tmr         <= '0;
			bit_cnt     <= '0;
			ps2_clk_low <= 1'b0;
			ps2_dat_low <= 1'b0;
			tx_done     <= 1'b0;
			tx_nack     <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			tx_nack <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (tx_start) begin
						sh          <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
						tmr         <= '0;
						ps2_clk_low <= 1'b1;
						state       <= ST_INHIBIT;
					end
				end
				ST_INHIBIT: begin
					tmr <= tmr + 1'b1;
					// start bit goes out while the clock is still held
					if (tmr == INH_HALF)
						ps2_dat_low <= ~sh[0];
					if (tmr == INH_LAST) begin
						ps2_clk_low <= 1'b0;
						tmr         <= '0;
						bit_cnt     <= '0;
						state       <= ST_REQUEST;
					end
				end
				ST_REQUEST, ST_SHIFT, ST_ACK: begin
					tmr <= tmr + 1'b1;
					if (fall) begin
						tmr     <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (state == ST_ACK) begin
							// device pulls data low in the ack slot
							tx_done <= ~dat_sync[1];
							tx_nack <= dat_sync[1];
							state   <= ST_IDLE;
						end else begin
							ps2_dat_low <= ~sh[1];
							sh          <= {1'b1, sh[10:1]};
							// tenth fall puts the stop bit out
							state <= (bit_cnt == 4'd9) ? ST_ACK : ST_SHIFT;
						end
					end else if (tmr == GAP_LAST) begin
						// device stopped clocking
						ps2_dat_low <= 1'b0;
						tx_nack     <= 1'b1;
						state       <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign tx_busy = (state != ST_IDLE);

	// clock line only held during the inhibit window
	assert property (@(posedge qzt_clk) disable iff (rst)
		ps2_clk_low |-> state == ST_INHIBIT)
		else $error("ps2_tx: clock held low outside inhibit");

endmodule

`default_nettype wire

/* tb_ps2_mouse.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_mouse;

	import ps2_pkg::*;

	localparam int HALF    = 10;
	localparam int INH     = 20;
	localparam int FTO     = 200;
	localparam int ACK_TO  = 2000;
	localparam int NUM_PKT = 8;
	// clock cycles for one frame plus its idle gap
	localparam int FRAME_CYC = 26 * HALF;
	localparam int WATCH_CYC = ((NUM_PKT + 4) * 3 + 12) * FRAME_CYC + 2 * ACK_TO + 2000;

	logic          qzt_clk;
	logic          rst;
	logic          start;
	logic          dut_clk_low;
	logic          dut_dat_low;
	logic          mdl_clk_low;
	logic          mdl_dat_low;
	logic          ps2_clk;
	logic          ps2_dat;
	logic          init_done;
	logic          init_err;
	logic          frame_err;
	mouse_packet_t packet;
	logic          packet_valid;

	int            errors;
	int            init_err_cnt;
	int            frame_err_cnt;
	int            pkt_cnt;
	logic [23:0]   exp_q[$];

	// open-collector lines with pull-ups
	assign ps2_clk = ~(dut_clk_low | mdl_clk_low);
	assign ps2_dat = ~(dut_dat_low | mdl_dat_low);

	ps2_mouse_top #(
		.INHIBIT_CYCLES       (INH),
		.FRAME_TIMEOUT_CYCLES (FTO),
		.ACK_TIMEOUT_CYCLES   (ACK_TO)
	) dut0 (
		.qzt_clk      (qzt_clk),
		.rst          (rst),
		.ps2_clk      (ps2_clk),
		.ps2_dat      (ps2_dat),
		.ps2_clk_low  (dut_clk_low),
		.ps2_dat_low  (dut_dat_low),
		.start        (start),
		.init_done    (init_done),
		.init_err     (init_err),
		.frame_err    (frame_err),
		.packet       (packet),
		.packet_valid (packet_valid)
	);

	ps2_mouse_model #(.HALF_CYCLES(HALF)) model0 (
		.qzt_clk (qzt_clk),
		.ps2_clk (ps2_clk),
		.ps2_dat (ps2_dat),
		.clk_low (mdl_clk_low),
		.dat_low (mdl_dat_low)
	);

	initial qzt_clk = 1'b0;
	always #50 qzt_clk = ~qzt_clk;

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic pulse_start();
		@(negedge qzt_clk);
		start = 1'b1;
		@(negedge qzt_clk);
		start = 1'b0;
	endtask

	task automatic send_packet(input logic [7:0] st, input logic [7:0] dx,
		input logic [7:0] dy);
		exp_q.push_back({st, dx, dy});
		model0.send_byte(st, 1'b0);
		model0.send_byte(dx, 1'b0);
		model0.send_byte(dy, 1'b0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// output monitor
	//////////////////////////////////////////////////////////////////////

	always @(negedge qzt_clk) begin
		logic [23:0] e;
		if (!rst) begin
			if (init_err)
				init_err_cnt++;
			if (frame_err)
				frame_err_cnt++;
			if (packet_valid) begin
				pkt_cnt++;
				assert (exp_q.size() != 0)
				else begin
					errors++;
					$display("packet_valid pulsed with no packet outstanding");
				end
				if (exp_q.size() != 0) begin
					e = exp_q.pop_front();
					check_val("packet.status", packet.status.raw, e[23:16]);
					check_val("packet.dx", packet.dx, e[15:8]);
					check_val("packet.dy", packet.dy, e[7:0]);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		int          n;
		int          base;
		logic [7:0]  exp_cmd [0:2];
		errors        = 0;
		init_err_cnt  = 0;
		frame_err_cnt = 0;
		pkt_cnt       = 0;
		rst           = 1'b1;
		start         = 1'b0;
		exp_cmd[0]    = 8'hF2;
		exp_cmd[1]    = 8'hEA;
		exp_cmd[2]    = 8'hF4;
		void'($urandom(32));
		repeat (3) @(negedge qzt_clk);
		rst = 1'b0;

		repeat (5) @(negedge qzt_clk);
		check_val("ps2_clk_low", dut_clk_low, 0);
		check_val("ps2_dat_low", dut_dat_low, 0);
		check_val("init_done", init_done, 0);
		check_val("packet_valid", packet_valid, 0);

		// no FA reply so the ack wait must expire
		model0.ack_mute = 1'b1;
		pulse_start();
		n = 0;
		while (init_err_cnt == 0 && n < ACK_TO + 4 * FRAME_CYC) begin
			@(negedge qzt_clk);
			n++;
		end
		check_val("init_err_cnt", init_err_cnt, 1);
		check_val("init_done", init_done, 0);

		model0.ack_mute = 1'b0;
		model0.cmd_cnt  = 0;
		base            = init_err_cnt;
		pulse_start();
		n = 0;
		while (!init_done && n < 8 * FRAME_CYC + 200) begin
			@(negedge qzt_clk);
			n++;
		end
		check_val("init_done", init_done, 1);
		check_val("init_err_cnt", init_err_cnt, base);
		check_val("cmd_cnt", model0.cmd_cnt, 3);
		for (int i = 0; i < 3; i++) begin
			check_val("cmd_byte", model0.cmd_log[i], exp_cmd[i]);
			check_val("cmd_parity_ok", model0.par_ok[i], 1);
		end

		// let the mouse finish its last ack frame
		repeat (2 * HALF) @(negedge qzt_clk);

		for (int i = 0; i < NUM_PKT; i++)
			send_packet(8'($urandom) | 8'h08, 8'($urandom), 8'($urandom));

		// bad parity in dx drops the whole packet
		base = frame_err_cnt;
		model0.send_byte(8'($urandom) | 8'h08, 1'b0);
		model0.send_byte(8'($urandom), 1'b1);
		check_val("frame_err_cnt", frame_err_cnt, base + 1);
		send_packet(8'($urandom) | 8'h08, 8'($urandom), 8'($urandom));

		// out of step byte with the always-one bit clear
		model0.send_byte(8'($urandom) & 8'hF7, 1'b0);
		send_packet(8'($urandom) | 8'h08, 8'($urandom), 8'($urandom));

		repeat (4 * HALF) @(negedge qzt_clk);
		check_val("pkt_cnt", pkt_cnt, NUM_PKT + 2);
		check_val("exp_q.size", exp_q.size(), 0);

		$display("errors %0d, packets %0d, frame errors %0d, init errors %0d",
			errors, pkt_cnt, frame_err_cnt, init_err_cnt);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCH_CYC * 100);
		$display("watchdog expired before the tests finished, errors %0d", errors);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
